//--- common/motorPwm_settings.svh
`ifndef MOTOR_PWM_SETTINGS_SVH
`define MOTOR_PWM_SETTINGS_SVH

// width of pulse accumulators and step lengths
`define MP_POS_W 16
// width of a PWM period length
`define MP_LEN_W 12
// commutation steps per electrical turn
`define MP_STEP_COUNT 12
// shortest pulse the bridge transistors can follow, in clk cycles
`define MP_MIN_PULSE 256
// both gates of a phase stay low this many cycles after a side change
`define MP_DEAD_TIME 4

// step offsets of the three phases
`define MP_PHASE_A 0
`define MP_PHASE_B 4
`define MP_PHASE_C 8

`endif

//--- common/motorPwmPkg.sv
`default_nettype none

`include "motorPwm_settings.svh"

package motorPwmPkg;

    // commutation step, 0 to 11
    typedef logic [3:0] stepNum_t;

    // count of high cycles
    typedef logic [`MP_POS_W-1:0] posWidth_t;

    // length of one PWM period
    typedef logic [`MP_LEN_W-1:0] periodLen_t;

    // why a pulse was or was not emitted at a period reload
    typedef enum logic [1:0] {
        noSkip     = 2'd0,
        minLimit   = 2'd1,
        noHighPull = 2'd2,
        noActive   = 2'd3
    } skipReason_t;

    // step as seen by a phase, the global step shifted by the phase offset
    function automatic stepNum_t phaseStep(stepNum_t step, int unsigned offset);
        int unsigned shifted;
        shifted = step + offset;
        if (shifted >= `MP_STEP_COUNT) begin
            shifted = shifted - `MP_STEP_COUNT;
        end
        return stepNum_t'(shifted);
    endfunction

endpackage

`default_nettype wire

//--- common/stepTimingIf.sv
`default_nettype none

// step number and step strobes, broadcast from the sequencer
interface stepTimingIf;

    motorPwmPkg::stepNum_t step;
    logic                  active;
    // one-cycle pulses on the first, second and last cycle of a step
    logic                  stepFirst;
    logic                  stepSecond;
    logic                  stepLast;

    modport source (
        output step,
        output active,
        output stepFirst,
        output stepSecond,
        output stepLast
    );

    modport sink (
        input step,
        input active,
        input stepFirst,
        input stepSecond,
        input stepLast
    );

endinterface

`default_nettype wire

//--- hdl/stepSequencer.sv
`default_nettype none

`include "motorPwm_settings.svh"

module stepSequencer (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   enable,
    input  motorPwmPkg::posWidth_t stepLen,
    stepTimingIf.source            timing
);
    import motorPwmPkg::*;

    posWidth_t cycleCnt;
    posWidth_t curLen;
    stepNum_t  step;
    logic      active;
    logic      stepFirst;
    logic      stepSecond;
    logic      stepLast;

    // the counter holds the remaining cycles of the step, curLen the length it started from
    assign stepFirst = active && (cycleCnt == curLen);
    assign stepLast  = active && (cycleCnt == posWidth_t'(1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            active   <= 1'b0;
            step     <= '0;
            cycleCnt <= '0;
            curLen   <= '0;
        end else if (!enable) begin
            active   <= 1'b0;
            step     <= '0;
            cycleCnt <= '0;
        end else if (!active) begin
            active   <= 1'b1;
            step     <= '0;
            cycleCnt <= stepLen;
            curLen   <= stepLen;
        end else if (stepLast) begin
            if (step == stepNum_t'(`MP_STEP_COUNT - 1)) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
            cycleCnt <= stepLen;
            curLen   <= stepLen;
        end else begin
            cycleCnt <= cycleCnt - 1'b1;
        end
    end

    // second-cycle strobe follows the first one
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepSecond <= 1'b0;
        end else begin
            stepSecond <= stepFirst && enable;
        end
    end

    assign timing.step       = step;
    assign timing.active     = active;
    assign timing.stepFirst  = stepFirst;
    assign timing.stepSecond = stepSecond;
    assign timing.stepLast   = stepLast;

endmodule

`default_nettype wire

//--- pwmGen/phasePwmGenerator.sv
`default_nettype none

`include "motorPwm_settings.svh"

module phasePwmGenerator #(
    parameter int unsigned phaseOffset = 0
) (
    input  logic                    clk,
    input  logic                    arstN,
    stepTimingIf.sink               timing,
    input  motorPwmPkg::periodLen_t pwmLenWant,
    input  motorPwmPkg::posWidth_t  pwmLenPos,
    input  motorPwmPkg::posWidth_t  sumNext,
    input  motorPwmPkg::posWidth_t  sumPrev,
    output motorPwmPkg::posWidth_t  posSum,
    output logic                    pwm,
    output motorPwmPkg::posWidth_t  stepLost,
    output logic                    stepLostValid
);
    import motorPwmPkg::*;

    stepNum_t    localStep;
    periodLen_t  periodCnt;
    logic        reload;
    posWidth_t   remain;
    posWidth_t   sum;
    posWidth_t   pulseLen;
    posWidth_t   pulseCnt;
    skipReason_t skip;
    posWidth_t   wantAcc;
    posWidth_t   realAcc;
    posWidth_t   wantLatched;
    posWidth_t   realLatched;
    logic        lostValid;

    assign localStep = phaseStep(timing.step, phaseOffset);

    // a new period begins at every step start and when the counter runs out
    assign reload = timing.active && (timing.stepFirst || periodCnt == periodLen_t'(1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
        end else if (!timing.active || reload) begin
            periodCnt <= pwmLenWant;
        end else begin
            periodCnt <= periodCnt - 1'b1;
        end
    end

    // width wanted in this period, including what earlier skipped periods left over
    assign sum = remain + pwmLenPos;

    // a pulse never outlasts its period
    assign pulseLen = (sum > posWidth_t'(pwmLenWant)) ? posWidth_t'(pwmLenWant) : sum;

    always_comb begin
        if (!timing.active || timing.step >= `MP_STEP_COUNT) begin
            skip = noActive;
        end else if (sum < `MP_MIN_PULSE) begin
            skip = minLimit;
        end else if (localStep == stepNum_t'(6) && sumNext < sum) begin
            skip = noHighPull;
        end else if (localStep == stepNum_t'(11) && sumPrev < sum) begin
            skip = noHighPull;
        end else begin
            skip = noSkip;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remain <= '0;
        end else if (!timing.active || timing.stepLast) begin
            remain <= '0;
        end else if (reload) begin
            case (skip)
                minLimit: remain <= sum;
                noSkip:   remain <= '0;
                default:  remain <= remain;
            endcase
        end
    end

    // pulse runs from the cycle after the reload and is cut at the end of the step
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pulseCnt <= '0;
        end else if (!timing.active || timing.stepLast) begin
            pulseCnt <= '0;
        end else if (reload && skip == noSkip) begin
            pulseCnt <= pulseLen;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = (pulseCnt != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wantAcc <= '0;
        end else if (!timing.active) begin
            wantAcc <= '0;
        end else if (timing.stepFirst) begin
            wantAcc <= pwmLenPos;
        end else if (reload) begin
            wantAcc <= wantAcc + pwmLenPos;
        end
    end

    // pwm is never high on the first cycle, so counting starts with the second
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            realAcc <= '0;
        end else if (!timing.active) begin
            realAcc <= '0;
        end else if (timing.stepSecond) begin
            realAcc <= posWidth_t'(pwm);
        end else if (pwm) begin
            realAcc <= realAcc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (timing.stepLast) begin
            wantLatched <= wantAcc;
            realLatched <= realAcc + posWidth_t'(pwm);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lostValid <= 1'b0;
        end else begin
            lostValid <= timing.stepLast;
        end
    end

    assign posSum        = sum;
    assign stepLost      = wantLatched - realLatched;
    assign stepLostValid = lostValid;

endmodule

`default_nettype wire

//--- pwmGen/gateDriver.sv
`default_nettype none

`include "motorPwm_settings.svh"

module gateDriver (
    input  logic      clk,
    input  logic      arstN,
    stepTimingIf.sink timing,
    input  logic      pwmA,
    input  logic      pwmB,
    input  logic      pwmC,
    output logic      gateHighA,
    output logic      gateHighB,
    output logic      gateHighC,
    output logic      gateLowA,
    output logic      gateLowB,
    output logic      gateLowC
);
    import motorPwmPkg::*;

    localparam int DeadW = $clog2(`MP_DEAD_TIME + 1);
    localparam int unsigned PhaseOffset [3] = '{`MP_PHASE_A, `MP_PHASE_B, `MP_PHASE_C};

    logic [2:0]       pwm;
    logic [2:0]       highSide;
    logic [2:0]       lastSide;
    logic [2:0]       gateHigh;
    logic [2:0]       gateLow;
    logic [DeadW-1:0] deadCnt [3];

    assign pwm = {pwmC, pwmB, pwmA};

    // first half of the turn drives the high side, idle counts as low side
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            highSide[i] = timing.active &&
                          (phaseStep(timing.step, PhaseOffset[i]) < stepNum_t'(6));
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lastSide <= '0;
            gateHigh <= '0;
            gateLow  <= '0;
            for (int i = 0; i < 3; i++) begin
                deadCnt[i] <= '0;
            end
        end else begin
            lastSide <= highSide;
            for (int i = 0; i < 3; i++) begin
                // a side change restarts the blanking window
                if (highSide[i] != lastSide[i]) begin
                    deadCnt[i] <= DeadW'(`MP_DEAD_TIME);
                end else if (deadCnt[i] != '0) begin
                    deadCnt[i] <= deadCnt[i] - 1'b1;
                end
                gateHigh[i] <= timing.active && pwm[i] && highSide[i] &&
                               highSide[i] == lastSide[i] && deadCnt[i] == '0;
                gateLow[i]  <= timing.active && pwm[i] && !highSide[i] &&
                               highSide[i] == lastSide[i] && deadCnt[i] == '0;
            end
        end
    end

    assign gateHighA = gateHigh[0];
    assign gateHighB = gateHigh[1];
    assign gateHighC = gateHigh[2];
    assign gateLowA  = gateLow[0];
    assign gateLowB  = gateLow[1];
    assign gateLowC  = gateLow[2];

endmodule

`default_nettype wire

//--- hdl/motorPwmTop.sv
`default_nettype none

`include "motorPwm_settings.svh"

module motorPwmTop (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    enable,
    input  motorPwmPkg::posWidth_t  stepLen,
    input  motorPwmPkg::periodLen_t pwmLenWant,
    input  motorPwmPkg::posWidth_t  pwmLenPos,
    output logic                    gateHighA,
    output logic                    gateHighB,
    output logic                    gateHighC,
    output logic                    gateLowA,
    output logic                    gateLowB,
    output logic                    gateLowC,
    output motorPwmPkg::stepNum_t   stepNow,
    output motorPwmPkg::posWidth_t  stepLostA,
    output logic                    stepLostValid
);
    import motorPwmPkg::*;

    posWidth_t posSumA;
    posWidth_t posSumB;
    posWidth_t posSumC;
    logic      pwmA;
    logic      pwmB;
    logic      pwmC;

    stepTimingIf timing ();

    stepSequencer stepSequencer_i (
        .clk     (clk),
        .arstN   (arstN),
        .enable  (enable),
        .stepLen (stepLen),
        .timing  (timing.source)
    );

    // each phase reads the sums of the other two, wired as a ring
    phasePwmGenerator #(.phaseOffset(`MP_PHASE_A)) phaseA_i (
        .clk           (clk),
        .arstN         (arstN),
        .timing        (timing.sink),
        .pwmLenWant    (pwmLenWant),
        .pwmLenPos     (pwmLenPos),
        .sumNext       (posSumB),
        .sumPrev       (posSumC),
        .posSum        (posSumA),
        .pwm           (pwmA),
        .stepLost      (stepLostA),
        .stepLostValid (stepLostValid)
    );

    phasePwmGenerator #(.phaseOffset(`MP_PHASE_B)) phaseB_i (
        .clk           (clk),
        .arstN         (arstN),
        .timing        (timing.sink),
        .pwmLenWant    (pwmLenWant),
        .pwmLenPos     (pwmLenPos),
        .sumNext       (posSumC),
        .sumPrev       (posSumA),
        .posSum        (posSumB),
        .pwm           (pwmB),
        .stepLost      (),
        .stepLostValid ()
    );

    phasePwmGenerator #(.phaseOffset(`MP_PHASE_C)) phaseC_i (
        .clk           (clk),
        .arstN         (arstN),
        .timing        (timing.sink),
        .pwmLenWant    (pwmLenWant),
        .pwmLenPos     (pwmLenPos),
        .sumNext       (posSumA),
        .sumPrev       (posSumB),
        .posSum        (posSumC),
        .pwm           (pwmC),
        .stepLost      (),
        .stepLostValid ()
    );

    gateDriver gateDriver_i (
        .clk       (clk),
        .arstN     (arstN),
        .timing    (timing.sink),
        .pwmA      (pwmA),
        .pwmB      (pwmB),
        .pwmC      (pwmC),
        .gateHighA (gateHighA),
        .gateHighB (gateHighB),
        .gateHighC (gateHighC),
        .gateLowA  (gateLowA),
        .gateLowB  (gateLowB),
        .gateLowC  (gateLowC)
    );

    assign stepNow = timing.step;

endmodule

`default_nettype wire

//--- test/motorPwmTb.sv
`default_nettype none

`include "motorPwm_settings.svh"

module motorPwmTb;
    timeunit 1ns;
    timeprecision 1ps;

    import motorPwmPkg::*;

    logic       clk = 1'b0;
    logic       arstN;
    logic       enable;
    posWidth_t  stepLen;
    periodLen_t pwmLenWant;
    posWidth_t  pwmLenPos;
    logic       gateHighA;
    logic       gateHighB;
    logic       gateHighC;
    logic       gateLowA;
    logic       gateLowB;
    logic       gateLowC;
    stepNum_t   stepNow;
    posWidth_t  stepLostA;
    logic       stepLostValid;

    int unsigned errorCount = 0;
    int unsigned testCount = 0;
    int unsigned failedTests = 0;
    logic [31:0] lcgState = 32'hf89a;

    // gate outputs are registered, so each sample belongs to the step of the cycle before
    int unsigned prevStep;
    int unsigned steerFaults;
    bit          highSeen;
    bit          lowSeen;

    motorPwmTop motorPwmTop_i (
        .clk           (clk),
        .arstN         (arstN),
        .enable        (enable),
        .stepLen       (stepLen),
        .pwmLenWant    (pwmLenWant),
        .pwmLenPos     (pwmLenPos),
        .gateHighA     (gateHighA),
        .gateHighB     (gateHighB),
        .gateHighC     (gateHighC),
        .gateLowA      (gateLowA),
        .gateLowB      (gateLowB),
        .gateLowC      (gateLowC),
        .stepNow       (stepNow),
        .stepLostA     (stepLostA),
        .stepLostValid (stepLostValid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic noteMismatch(input string testName, input string what,
                                input int unsigned expected, input int unsigned actual);
        $display("mismatch %s %s: expected %0d actual %0d", testName, what, expected, actual);
        errorCount++;
    endtask

    task automatic finishTest(input string testName, input int unsigned errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %s finished without errors", testName);
        end else begin
            failedTests++;
            $display("test %s finished with %0d errors", testName, errorCount - errorsBefore);
        end
    endtask

    task automatic applyReset();
        arstN  = 1'b0;
        enable = 1'b0;
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
    endtask

    // returns on the first cycle of step 0 with the sequencer running
    task automatic startRun(input int unsigned len, input int unsigned period,
                            input int unsigned width);
        applyReset();
        stepLen    = posWidth_t'(len);
        pwmLenWant = periodLen_t'(period);
        pwmLenPos  = posWidth_t'(width);
        enable     = 1'b1;
        prevStep   = 0;
        @(negedge clk);
    endtask

    // follows one step from its first cycle until stepNow moves on
    task automatic watchStep(input string testName, input int unsigned limit,
                             output int unsigned stepSeen, output int unsigned cycles,
                             output int unsigned pulses, output int unsigned lostSeen,
                             output bit lostFlag);
        stepSeen = stepNow;
        cycles   = 0;
        pulses   = 0;
        lostSeen = 0;
        lostFlag = 1'b0;
        while (stepNow == stepSeen && cycles < limit) begin
            cycles++;
            if (gateHighA || gateLowA) begin
                pulses++;
            end
            if ((gateHighA && prevStep >= 6) || (gateLowA && prevStep < 6)) begin
                steerFaults++;
            end
            if ((gateHighA && gateLowA) || (gateHighB && gateLowB) ||
                (gateHighC && gateLowC)) begin
                steerFaults++;
            end
            highSeen = highSeen || gateHighA;
            lowSeen  = lowSeen || gateLowA;
            if (stepLostValid) begin
                lostSeen = stepLostA;
                lostFlag = 1'b1;
            end
            prevStep = stepNow;
            @(negedge clk);
        end
        if (stepNow == stepSeen) begin
            $display("%s: stepNow stayed at %0d for more than %0d cycles",
                     testName, stepSeen, limit);
            errorCount++;
        end
    endtask

    // one full turn after the first step, checking phase A pulse counts and deficits
    task automatic checkTurn(input string testName, input int unsigned len,
                             input int unsigned period, input int unsigned width,
                             input int unsigned expPlain, input int unsigned expDead,
                             input int unsigned expLost);
        int unsigned stepSeen;
        int unsigned cycles;
        int unsigned pulses;
        int unsigned lost;
        int unsigned expStep;
        int unsigned expCount;
        bit          lostFlag;
        int          i;
        startRun(len, period, width);
        // the first step starts from idle and is only watched
        watchStep(testName, len + 8, stepSeen, cycles, pulses, lost, lostFlag);
        for (i = 1; i <= `MP_STEP_COUNT + 1; i++) begin
            watchStep(testName, len + 8, stepSeen, cycles, pulses, lost, lostFlag);
            expStep = i % `MP_STEP_COUNT;
            if (stepSeen != expStep) begin
                noteMismatch(testName, "step number", expStep, stepSeen);
            end
            // the deficit of the previous step shows up on the first cycle of this one
            if (!lostFlag) begin
                $display("%s: no stepLostValid pulse seen during step %0d", testName, stepSeen);
                errorCount++;
            end else if (lost != expLost) begin
                noteMismatch(testName, "stepLostA", expLost, lost);
            end
            if (i <= `MP_STEP_COUNT) begin
                expCount = (expStep == 0 || expStep == 6) ? expDead : expPlain;
                if (pulses != expCount) begin
                    noteMismatch(testName, $sformatf("pulse count in step %0d", expStep),
                                 expCount, pulses);
                end
            end
        end
        enable = 1'b0;
        @(negedge clk);
    endtask

    task automatic resetIdleTest();
        int unsigned errorsBefore;
        int          i;
        errorsBefore = errorCount;
        stepLen      = 16'd50;
        pwmLenWant   = 12'd400;
        pwmLenPos    = 16'd300;
        applyReset();
        for (i = 0; i < 50; i++) begin
            if ({gateHighA, gateHighB, gateHighC, gateLowA, gateLowB, gateLowC,
                 stepLostValid, stepNow} != '0) begin
                noteMismatch("resetIdle", $sformatf("outputs in cycle %0d", i), 0,
                             {gateHighA, gateHighB, gateHighC, gateLowA, gateLowB, gateLowC,
                              stepLostValid, stepNow});
            end
            @(negedge clk);
        end
        finishTest("resetIdle", errorsBefore);
    endtask

    task automatic stepSequenceTest();
        int unsigned errorsBefore;
        int unsigned stepSeen;
        int unsigned cycles;
        int unsigned pulses;
        int unsigned lost;
        bit          lostFlag;
        int          i;
        errorsBefore = errorCount;
        startRun(37, 400, 300);
        for (i = 0; i <= `MP_STEP_COUNT; i++) begin
            watchStep("stepSequence", 45, stepSeen, cycles, pulses, lost, lostFlag);
            if (stepSeen != i % `MP_STEP_COUNT) begin
                noteMismatch("stepSequence", "step number", i % `MP_STEP_COUNT, stepSeen);
            end
            if (cycles != 37) begin
                noteMismatch("stepSequence", $sformatf("length of step %0d", stepSeen),
                             37, cycles);
            end
        end
        enable = 1'b0;
        @(negedge clk);
        finishTest("stepSequence", errorsBefore);
    endtask

    // four periods of 300 cycles per step, all pulses above the minimum
    task automatic fullPulsesTest();
        int unsigned errorsBefore;
        errorsBefore = errorCount;
        // the generator counts its own pulses before the driver blanks them
        checkTurn("fullPulses", 1200, 300, 280, 4 * 280, 4 * 280 - `MP_DEAD_TIME, 0);
        finishTest("fullPulses", errorsBefore);
    endtask

    // 100-cycle width is carried twice and then sent as one 300-cycle pulse
    task automatic minPulseCarryTest();
        int unsigned errorsBefore;
        errorsBefore = errorCount;
        checkTurn("minPulseCarry", 2400, 400, 100, 600, 600, 0);
        finishTest("minPulseCarry", errorsBefore);
    endtask

    task automatic sideSteeringTest();
        int unsigned errorsBefore;
        int unsigned stepSeen;
        int unsigned cycles;
        int unsigned pulses;
        int unsigned lost;
        bit          lostFlag;
        int          i;
        errorsBefore = errorCount;
        steerFaults  = 0;
        highSeen     = 1'b0;
        lowSeen      = 1'b0;
        // pulses reach the last cycle of each step, so the delayed gate crosses every boundary
        startRun(600, 300, 299);
        for (i = 0; i <= `MP_STEP_COUNT; i++) begin
            watchStep("sideSteering", 608, stepSeen, cycles, pulses, lost, lostFlag);
        end
        enable = 1'b0;
        @(negedge clk);
        if (steerFaults != 0) begin
            noteMismatch("sideSteering", "gate steering faults", 0, steerFaults);
        end
        if (!highSeen || !lowSeen) begin
            $display("sideSteering: gateHighA or gateLowA never went high during a turn");
            errorCount++;
        end
        finishTest("sideSteering", errorsBefore);
    endtask

    task automatic randomWidthsTest();
        int unsigned errorsBefore;
        int unsigned width;
        int          n;
        errorsBefore = errorCount;
        for (n = 0; n < 10; n++) begin
            width = `MP_MIN_PULSE + ((nextRandom() >> 8) % (500 - `MP_MIN_PULSE));
            checkTurn($sformatf("randomWidths[%0d]", width), 1000, 500, width,
                      2 * width, 2 * width - `MP_DEAD_TIME, 0);
        end
        finishTest("randomWidths", errorsBefore);
    endtask

    initial begin
        arstN      = 1'b0;
        enable     = 1'b0;
        stepLen    = '0;
        pwmLenWant = '0;
        pwmLenPos  = '0;
        resetIdleTest();
        stepSequenceTest();
        fullPulsesTest();
        minPulseCarryTest();
        sideSteeringTest();
        randomWidthsTest();
        $display("tests %0d, failed tests %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/motorPwmPkg.sv
common/stepTimingIf.sv
hdl/stepSequencer.sv
pwmGen/phasePwmGenerator.sv
pwmGen/gateDriver.sv
hdl/motorPwmTop.sv
test/motorPwmTb.sv
